// File: rtl/core_ctrl_pkg.sv
// core control package
// stream IDs, setting addresses, compat words and shared types
`default_nettype none

package core_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // stream routing
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] L0_CTRL_SID = 8'h40;
    // radio control stream, not handled locally
    localparam logic [7:0] R0_CTRL_SID = 8'h10;
    localparam logic [7:0] SID_MASK    = 8'hf0;

    ////////////////////////////////////////////////////////////
    // setting bus addresses
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] SR_CORE_MISC     = 8'd16;
    localparam logic [7:0] SR_CORE_READBACK = 8'd32;
    localparam logic [7:0] SR_CORE_PPS_SEL  = 8'd48;

    // readback word 0
    localparam logic [15:0] COMPAT_MAJOR     = 16'h0001;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hACE0BA5E;

    // set in every response header
    localparam int RESP_FLAG_BIT = 63;

    // control FIFO geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    typedef logic [63:0] ctrl_word_t;
    typedef logic [7:0]  sid_t;
    typedef logic [15:0] seqnum_t;
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;
    typedef logic [1:0]  rb_sel_t;
    typedef logic [1:0]  pps_sel_t;

    typedef enum logic [2:0] {
        S_HDR,
        S_PAYLOAD,
        S_WRITE,
        S_RESP_HDR,
        S_RESP_DATA
    } proc_state_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_stream_if.sv
// control stream bundle
// one 64-bit beat with tlast and a valid/ready handshake
`default_nettype none

interface ctrl_stream_if import core_ctrl_pkg::*; ();

    ctrl_word_t tdata;
    logic       tlast;
    logic       tvalid;
    logic       tready;

    modport source (
        output tdata,
        output tlast,
        output tvalid,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

`default_nettype wire

// File: rtl/ctrl_sid_router.sv
// control stream router
// keeps packets for the local stream ID, swallows everything else
`default_nettype none

module ctrl_sid_router import core_ctrl_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst,
    input  ctrl_word_t    i_ctrl_tdata,
    input  logic          i_ctrl_tlast,
    input  logic          i_ctrl_tvalid,
    output logic          o_ctrl_tready,
    ctrl_stream_if.source o_route
);

    sid_t hdr_sid;
    logic hdr_match;
    logic in_pkt;
    logic keep_r;
    logic keep;
    logic in_beat;

    // only meaningful on the first beat of a packet
    assign hdr_sid   = i_ctrl_tdata[7:0];
    assign hdr_match = ((hdr_sid & SID_MASK) == L0_CTRL_SID);

    // destination is held from the header until tlast
    assign keep = in_pkt ? keep_r : hdr_match;

    ////////////////////////////////////////////////////////////
    // forward path
    ////////////////////////////////////////////////////////////
    assign o_route.tdata  = i_ctrl_tdata;
    assign o_route.tlast  = i_ctrl_tlast;
    assign o_route.tvalid = i_ctrl_tvalid && keep;

    // dropped packets drain at full rate
    assign o_ctrl_tready = keep ? o_route.tready : 1'b1;

    assign in_beat = i_ctrl_tvalid && o_ctrl_tready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_pkt <= 1'b0;
            keep_r <= 1'b0;
        end else if (in_beat) begin
            in_pkt <= !i_ctrl_tlast;
            keep_r <= keep;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ctrl_fifo.sv
// control beat FIFO
// small circular buffer of {tlast, tdata} between router and processor
`default_nettype none

module ctrl_fifo import core_ctrl_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst,
    ctrl_stream_if.sink   i_wr,
    ctrl_stream_if.source o_rd
);

    logic [64:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               do_wr;
    logic               do_rd;

    assign i_wr.tready = (count != FIFO_CW'(FIFO_DEPTH));
    assign o_rd.tvalid = (count != '0);

    assign do_wr = i_wr.tvalid && i_wr.tready;
    assign do_rd = o_rd.tvalid && o_rd.tready;

    // head entry drives the output directly
    assign o_rd.tlast = mem[rd_ptr][64];
    assign o_rd.tdata = mem[rd_ptr][63:0];

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= {i_wr.tlast, i_wr.tdata};
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ctrl_cmd_proc.sv
// control command processor
// parses two-beat packets, writes a setting and answers each packet
`default_nettype none

module ctrl_cmd_proc import core_ctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst,
    ctrl_stream_if.sink i_cmd,
    output ctrl_word_t  o_resp_tdata,
    output logic        o_resp_tlast,
    output logic        o_resp_tvalid,
    input  logic        i_resp_tready,
    output logic        o_set_stb,
    output set_addr_t   o_set_addr,
    output set_data_t   o_set_data,
    input  ctrl_word_t  i_readback
);

    proc_state_t state;
    sid_t        sid_r;
    seqnum_t     seq_r;
    set_addr_t   addr_r;
    set_data_t   data_r;
    ctrl_word_t  rb_r;
    ctrl_word_t  resp_hdr;
    logic        drain_r;
    logic        cmd_beat;

    // input stalls for the whole write and response
    assign i_cmd.tready = (state == S_HDR) || (state == S_PAYLOAD);
    assign cmd_beat     = i_cmd.tvalid && i_cmd.tready;

    ////////////////////////////////////////////////////////////
    // packet state machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= S_HDR;
            drain_r <= 1'b0;
        end else begin
            case (state)
                S_HDR: begin
                    if (cmd_beat) begin
                        if (drain_r) begin
                            // leftover beats of an overlong packet
                            if (i_cmd.tlast) begin
                                drain_r <= 1'b0;
                            end
                        end else if (i_cmd.tlast) begin
                            // header only, answer without a write
                            state <= S_RESP_HDR;
                        end else begin
                            state <= S_PAYLOAD;
                        end
                    end
                end
                S_PAYLOAD: begin
                    if (cmd_beat) begin
                        drain_r <= !i_cmd.tlast;
                        state   <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    state <= S_RESP_HDR;
                end
                S_RESP_HDR: begin
                    if (i_resp_tready) begin
                        state <= S_RESP_DATA;
                    end
                end
                S_RESP_DATA: begin
                    if (i_resp_tready) begin
                        state <= S_HDR;
                    end
                end
                default: begin
                    state <= S_HDR;
                end
            endcase
        end
    end

    // captured fields
    always_ff @(posedge i_clk) begin
        if (state == S_HDR && cmd_beat && !drain_r) begin
            sid_r <= i_cmd.tdata[7:0];
            seq_r <= i_cmd.tdata[23:8];
        end
        if (state == S_PAYLOAD && cmd_beat) begin
            addr_r <= i_cmd.tdata[39:32];
            data_r <= i_cmd.tdata[31:0];
        end
        // write has landed by now, last sample is taken on the header handshake
        if (state == S_RESP_HDR) begin
            rb_r <= i_readback;
        end
    end

    ////////////////////////////////////////////////////////////
    // setting bus and response
    ////////////////////////////////////////////////////////////
    assign o_set_stb  = (state == S_WRITE);
    assign o_set_addr = addr_r;
    assign o_set_data = data_r;

    always_comb begin
        resp_hdr                = '0;
        resp_hdr[RESP_FLAG_BIT] = 1'b1;
        resp_hdr[23:8]          = seq_r;
        resp_hdr[7:0]           = sid_r;
    end

    assign o_resp_tvalid = (state == S_RESP_HDR) || (state == S_RESP_DATA);
    assign o_resp_tlast  = (state == S_RESP_DATA);
    assign o_resp_tdata  = (state == S_RESP_DATA) ? rb_r : resp_hdr;

endmodule

`default_nettype wire

// File: rtl/core_settings.sv
// core settings block
// setting registers, lock and PPS synchronizers, PPS mux and readback
`default_nettype none

module core_settings import core_ctrl_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_set_stb,
    input  set_addr_t  i_set_addr,
    input  set_data_t  i_set_data,
    output ctrl_word_t o_readback,
    input  logic [1:0] i_lock_signals,
    input  logic [31:0] i_rb_misc,
    input  logic       i_pps_ext,
    input  logic       i_pps_int,
    output logic       o_pps,
    output logic       o_ext_ref_is_pps,
    output set_data_t  o_misc_outs
);

    set_data_t  misc_r;
    rb_sel_t    rb_sel;
    pps_sel_t   pps_sel;
    logic [3:0] sync_meta;
    logic [3:0] sync_q;
    logic [1:0] lock_q;
    logic       pps_ext_q;
    logic       pps_int_q;

    ////////////////////////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            misc_r  <= '0;
            rb_sel  <= '0;
            pps_sel <= '0;
        end else if (i_set_stb) begin
            case (i_set_addr)
                SR_CORE_MISC:     misc_r  <= i_set_data;
                SR_CORE_READBACK: rb_sel  <= rb_sel_t'(i_set_data[1:0]);
                SR_CORE_PPS_SEL:  pps_sel <= pps_sel_t'(i_set_data[1:0]);
                default:          misc_r  <= misc_r;
            endcase
        end
    end

    assign o_misc_outs = misc_r;

    // two-flop synchronizers, {lock, ext pps, int pps}
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= {i_lock_signals, i_pps_ext, i_pps_int};
            sync_q    <= sync_meta;
        end
    end

    assign lock_q    = sync_q[3:2];
    assign pps_ext_q = sync_q[1];
    assign pps_int_q = sync_q[0];

    // pps source select
    assign o_pps = (pps_sel == 2'b01) ? pps_ext_q :
                   (pps_sel == 2'b10) ? pps_int_q : 1'b0;
    assign o_ext_ref_is_pps = (pps_sel == 2'b01);

    ////////////////////////////////////////////////////////////
    // readback mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (rb_sel)
            2'd0:    o_readback = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1:    o_readback = {32'd0, misc_r};
            2'd2:    o_readback = {24'd0, 8'd1, i_rb_misc};
            default: o_readback = {62'd0, lock_q};
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/core_ctrl_top.sv
// core control path top
// router, FIFO, command processor and settings on one clock
`default_nettype none

module core_ctrl_top import core_ctrl_pkg::*; (
    // radio_clk domain, bus_rst
    input  logic        i_clk,
    input  logic        i_rst,

    // control packets in
    input  ctrl_word_t  i_ctrl_tdata,
    input  logic        i_ctrl_tlast,
    input  logic        i_ctrl_tvalid,
    output logic        o_ctrl_tready,

    // responses out
    output ctrl_word_t  o_resp_tdata,
    output logic        o_resp_tlast,
    output logic        o_resp_tvalid,
    input  logic        i_resp_tready,

    // core status and controls
    input  logic [1:0]  i_lock_signals,
    input  logic [31:0] i_rb_misc,
    input  logic        i_pps_ext,
    input  logic        i_pps_int,
    output logic        o_pps,
    output logic        o_ext_ref_is_pps,
    output set_data_t   o_misc_outs
);

    ctrl_stream_if route_if ();
    ctrl_stream_if proc_if ();

    logic       set_stb;
    set_addr_t  set_addr;
    set_data_t  set_data;
    ctrl_word_t readback;

    ////////////////////////////////////////////////////////////
    // control path
    ////////////////////////////////////////////////////////////
    ctrl_sid_router router_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ctrl_tdata  (i_ctrl_tdata),
        .i_ctrl_tlast  (i_ctrl_tlast),
        .i_ctrl_tvalid (i_ctrl_tvalid),
        .o_ctrl_tready (o_ctrl_tready),
        .o_route       (route_if.source)
    );

    ctrl_fifo fifo_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_wr  (route_if.sink),
        .o_rd  (proc_if.source)
    );

    ctrl_cmd_proc proc_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cmd         (proc_if.sink),
        .o_resp_tdata  (o_resp_tdata),
        .o_resp_tlast  (o_resp_tlast),
        .o_resp_tvalid (o_resp_tvalid),
        .i_resp_tready (i_resp_tready),
        .o_set_stb     (set_stb),
        .o_set_addr    (set_addr),
        .o_set_data    (set_data),
        .i_readback    (readback)
    );

    // settings and synchronizers
    core_settings settings_i (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_set_stb        (set_stb),
        .i_set_addr       (set_addr),
        .i_set_data       (set_data),
        .o_readback       (readback),
        .i_lock_signals   (i_lock_signals),
        .i_rb_misc        (i_rb_misc),
        .i_pps_ext        (i_pps_ext),
        .i_pps_int        (i_pps_int),
        .o_pps            (o_pps),
        .o_ext_ref_is_pps (o_ext_ref_is_pps),
        .o_misc_outs      (o_misc_outs)
    );

endmodule

`default_nettype wire

// File: tb/core_ctrl_assertions.sv
// response stream checks for the core control path
`default_nettype none

module core_ctrl_assertions import core_ctrl_pkg::*; (
    input logic       i_clk,
    input logic       i_rst,
    input ctrl_word_t o_resp_tdata,
    input logic       o_resp_tlast,
    input logic       o_resp_tvalid,
    input logic       i_resp_tready
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // response handshake
    ////////////////////////////////////////////////////////////
    // a stalled beat stays put until it is taken
    a_resp_hold: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_resp_tvalid && !i_resp_tready) |=>
            (o_resp_tvalid && $stable(o_resp_tdata) && $stable(o_resp_tlast))
    ) else $error("response beat changed while stalled");

    a_resp_idle_after_rst: assert property (
        @(posedge i_clk) $fell(i_rst) |-> !o_resp_tvalid
    ) else $error("response valid high in the first cycle after reset");

endmodule

bind core_ctrl_top core_ctrl_assertions assertions_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .o_resp_tdata  (o_resp_tdata),
    .o_resp_tlast  (o_resp_tlast),
    .o_resp_tvalid (o_resp_tvalid),
    .i_resp_tready (i_resp_tready)
);

`default_nettype wire

// File: tb/tb_core_ctrl.sv
// control path testbench
// table-driven packets with random response back-pressure and response checks
`default_nettype none

module tb_core_ctrl import core_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PKTS       = 16;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 40 + 200;

    localparam logic [1:0]  LOCK_VALUE    = 2'b10;
    localparam logic [31:0] RB_MISC_VALUE = 32'h5a5a_c3c3;

    // short aliases keep the table readable
    localparam set_addr_t A_MISC = SR_CORE_MISC;
    localparam set_addr_t A_RB   = SR_CORE_READBACK;
    localparam set_addr_t A_PPS  = SR_CORE_PPS_SEL;

    // expected readback words
    localparam ctrl_word_t EXP_SIG    = 64'hACE0_BA5E_0001_0000;
    localparam ctrl_word_t EXP_MISC_A = 64'h0000_0000_dead_beef;
    localparam ctrl_word_t EXP_MISC_B = 64'h0000_0000_cafe_f00d;
    localparam ctrl_word_t EXP_MISC_C = 64'h0000_0000_0bad_cafe;
    localparam ctrl_word_t EXP_RBM    = {24'd0, 8'd1, RB_MISC_VALUE};
    localparam ctrl_word_t EXP_LOCK   = {62'd0, LOCK_VALUE};

    // extra check once the response is back
    localparam logic [1:0] K_NONE = 2'd0;
    localparam logic [1:0] K_MISC = 2'd1;
    localparam logic [1:0] K_PPS  = 2'd2;

    typedef struct packed {
        sid_t       sid;
        seqnum_t    seq;
        set_addr_t  addr;
        set_data_t  data;
        logic       resp;
        logic [1:0] kind;
        ctrl_word_t exp_rb;
    } pkt_t;

    logic        radio_clk;
    logic        bus_rst;
    ctrl_word_t  i_ctrl_tdata;
    logic        i_ctrl_tlast;
    logic        i_ctrl_tvalid;
    logic        o_ctrl_tready;
    ctrl_word_t  o_resp_tdata;
    logic        o_resp_tlast;
    logic        o_resp_tvalid;
    logic        i_resp_tready = 1'b0;
    logic [1:0]  i_lock_signals;
    logic [31:0] i_rb_misc;
    logic        i_pps_ext;
    logic        i_pps_int;
    logic        o_pps;
    logic        o_ext_ref_is_pps;
    set_data_t   o_misc_outs;

    pkt_t       pkt_tbl [NUM_PKTS];
    pkt_t       exp_q [$];
    int         err_count;
    int         resp_count;
    int         cycle_count = 0;
    integer     seed = 32'he6c7;
    logic       beat_is_data;
    logic       stall_held;
    ctrl_word_t held_data;
    logic       held_last;

    core_ctrl_top dut_i (
        .i_clk            (radio_clk),
        .i_rst            (bus_rst),
        .i_ctrl_tdata     (i_ctrl_tdata),
        .i_ctrl_tlast     (i_ctrl_tlast),
        .i_ctrl_tvalid    (i_ctrl_tvalid),
        .o_ctrl_tready    (o_ctrl_tready),
        .o_resp_tdata     (o_resp_tdata),
        .o_resp_tlast     (o_resp_tlast),
        .o_resp_tvalid    (o_resp_tvalid),
        .i_resp_tready    (i_resp_tready),
        .i_lock_signals   (i_lock_signals),
        .i_rb_misc        (i_rb_misc),
        .i_pps_ext        (i_pps_ext),
        .i_pps_int        (i_pps_int),
        .o_pps            (o_pps),
        .o_ext_ref_is_pps (o_ext_ref_is_pps),
        .o_misc_outs      (o_misc_outs)
    );

    always #5 radio_clk = ~radio_clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic pkt_t make_entry(input sid_t sid, input seqnum_t seq,
                                        input set_addr_t addr, input set_data_t data,
                                        input logic resp, input logic [1:0] kind,
                                        input ctrl_word_t exp_rb);
        pkt_t p;
        p.sid    = sid;
        p.seq    = seq;
        p.addr   = addr;
        p.data   = data;
        p.resp   = resp;
        p.kind   = kind;
        p.exp_rb = exp_rb;
        return p;
    endfunction

    task automatic load_table();
        pkt_tbl[0]  = make_entry(8'h40, 16'h0101, A_MISC, 32'hdead_beef, 1'b1, K_MISC, EXP_SIG);
        pkt_tbl[1]  = make_entry(8'h40, 16'h0102, A_RB, 32'd1, 1'b1, K_NONE, EXP_MISC_A);
        // radio and unknown IDs are swallowed
        pkt_tbl[2]  = make_entry(8'h10, 16'h0103, A_MISC, 32'h1111_1111, 1'b0, K_NONE, 64'd0);
        pkt_tbl[3]  = make_entry(8'h7f, 16'h0104, A_MISC, 32'h2222_2222, 1'b0, K_NONE, 64'd0);
        pkt_tbl[4]  = make_entry(8'h4a, 16'h0105, A_RB, 32'd1, 1'b1, K_NONE, EXP_MISC_A);
        pkt_tbl[5]  = make_entry(8'h40, 16'h0106, A_RB, 32'd2, 1'b1, K_NONE, EXP_RBM);
        pkt_tbl[6]  = make_entry(8'h40, 16'h0107, A_RB, 32'd3, 1'b1, K_NONE, EXP_LOCK);
        pkt_tbl[7]  = make_entry(8'h40, 16'h0108, A_RB, 32'd0, 1'b1, K_NONE, EXP_SIG);
        pkt_tbl[8]  = make_entry(8'h40, 16'h0109, A_PPS, 32'd1, 1'b1, K_PPS, EXP_SIG);
        pkt_tbl[9]  = make_entry(8'h40, 16'h010a, A_PPS, 32'd2, 1'b1, K_PPS, EXP_SIG);
        pkt_tbl[10] = make_entry(8'h40, 16'h010b, A_PPS, 32'd0, 1'b1, K_PPS, EXP_SIG);
        pkt_tbl[11] = make_entry(8'h40, 16'h010c, A_MISC, 32'hcafe_f00d, 1'b1, K_MISC, EXP_SIG);
        pkt_tbl[12] = make_entry(8'h40, 16'h010d, A_RB, 32'd1, 1'b1, K_NONE, EXP_MISC_B);
        pkt_tbl[13] = make_entry(8'h10, 16'h010e, A_RB, 32'd3, 1'b0, K_NONE, 64'd0);
        // readback of misc is taken after this write lands
        pkt_tbl[14] = make_entry(8'h40, 16'h010f, A_MISC, 32'h0bad_cafe, 1'b1, K_NONE, EXP_MISC_C);
        pkt_tbl[15] = make_entry(8'h40, 16'h0110, A_RB, 32'd0, 1'b1, K_NONE, EXP_SIG);
    endtask

    // entered on a rising edge and returns on the edge that moves the beat
    task automatic send_beat(input ctrl_word_t data, input logic last, input logic drop);
        logic taken;
        i_ctrl_tdata  <= data;
        i_ctrl_tlast  <= last;
        i_ctrl_tvalid <= 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge radio_clk);
            taken = o_ctrl_tready;
            // swallowed packets never see back-pressure
            if (drop) begin
                check_value("o_ctrl_tready", 64'(taken), 64'd1);
            end
            @(posedge radio_clk);
        end
    endtask

    task automatic send_packet(input pkt_t p);
        ctrl_word_t hdr;
        ctrl_word_t pay;
        hdr       = '0;
        hdr[23:8] = p.seq;
        hdr[7:0]  = p.sid;
        pay        = '0;
        pay[39:32] = p.addr;
        pay[31:0]  = p.data;
        if (p.resp) begin
            exp_q.push_back(p);
        end
        send_beat(hdr, 1'b0, !p.resp);
        send_beat(pay, 1'b1, !p.resp);
    endtask

    task automatic wait_idle();
        @(negedge radio_clk);
        while (exp_q.size() != 0) begin
            @(negedge radio_clk);
        end
    endtask

    // toggle both PPS inputs the opposite way and watch the selected one
    task automatic pps_check(input pps_sel_t sel);
        logic ext_v;
        logic int_v;
        logic exp_pps;
        int   k;
        for (k = 0; k < 2; k++) begin
            ext_v = (k == 0);
            int_v = (k != 0);
            @(posedge radio_clk);
            i_pps_ext <= ext_v;
            i_pps_int <= int_v;
            repeat (3) @(posedge radio_clk);
            @(negedge radio_clk);
            exp_pps = (sel == 2'b01) ? ext_v : (sel == 2'b10) ? int_v : 1'b0;
            check_value("o_pps", 64'(o_pps), 64'(exp_pps));
            check_value("o_ext_ref_is_pps", 64'(o_ext_ref_is_pps), 64'(sel == 2'b01));
        end
    endtask

    task automatic take_beat();
        ctrl_word_t exp_hdr;
        if (exp_q.size() == 0) begin
            err_count++;
            $display("A response beat arrived with no packet outstanding");
        end else if (!beat_is_data) begin
            exp_hdr            = '0;
            exp_hdr[RESP_FLAG_BIT] = 1'b1;
            exp_hdr[23:8]      = exp_q[0].seq;
            exp_hdr[7:0]       = exp_q[0].sid;
            check_value("o_resp_tdata", o_resp_tdata, exp_hdr);
            check_value("o_resp_tlast", 64'(o_resp_tlast), 64'd0);
        end else begin
            check_value("o_resp_tdata", o_resp_tdata, exp_q[0].exp_rb);
            check_value("o_resp_tlast", 64'(o_resp_tlast), 64'd1);
            void'(exp_q.pop_front());
            resp_count++;
        end
        beat_is_data = !beat_is_data;
    endtask

    ////////////////////////////////////////////////////////////
    // response side
    ////////////////////////////////////////////////////////////
    always @(posedge radio_clk) begin
        if (bus_rst) begin
            i_resp_tready <= 1'b0;
        end else begin
            i_resp_tready <= (($random(seed) & 3) != 0);
        end
    end

    // sampled mid-cycle so a stalled beat can be compared next time
    always @(negedge radio_clk) begin
        if (!bus_rst) begin
            if (stall_held) begin
                if (!o_resp_tvalid) begin
                    err_count++;
                    $display("Response valid dropped while the beat was stalled");
                end else begin
                    check_value("o_resp_tdata", o_resp_tdata, held_data);
                    check_value("o_resp_tlast", 64'(o_resp_tlast), 64'(held_last));
                end
            end
            stall_held = 1'b0;
            if (o_resp_tvalid) begin
                if (i_resp_tready) begin
                    take_beat();
                end else begin
                    stall_held = 1'b1;
                    held_data  = o_resp_tdata;
                    held_last  = o_resp_tlast;
                end
            end
        end
    end

    always @(posedge radio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin : main_seq
        int i;
        radio_clk      = 1'b0;
        bus_rst        <= 1'b1;
        i_ctrl_tdata   <= '0;
        i_ctrl_tlast   <= 1'b0;
        i_ctrl_tvalid  <= 1'b0;
        i_lock_signals <= LOCK_VALUE;
        i_rb_misc      <= RB_MISC_VALUE;
        i_pps_ext      <= 1'b0;
        i_pps_int      <= 1'b0;
        err_count      = 0;
        resp_count     = 0;
        beat_is_data   = 1'b0;
        stall_held     = 1'b0;
        held_data      = '0;
        held_last      = 1'b0;
        load_table();

        repeat (16) @(posedge radio_clk);
        bus_rst <= 1'b0;
        @(posedge radio_clk);

        for (i = 0; i < NUM_PKTS; i++) begin
            send_packet(pkt_tbl[i]);
            if (pkt_tbl[i].kind != K_NONE) begin
                i_ctrl_tvalid <= 1'b0;
                wait_idle();
                if (pkt_tbl[i].kind == K_MISC) begin
                    check_value("o_misc_outs", 64'(o_misc_outs), 64'(pkt_tbl[i].data));
                end else begin
                    pps_check(pkt_tbl[i].data[1:0]);
                end
                @(posedge radio_clk);
            end
        end
        i_ctrl_tvalid <= 1'b0;
        wait_idle();

        // nothing more may come out after the last answer
        repeat (20) @(posedge radio_clk);

        $display("Summary: %0d errors, %0d responses, %0d cycles",
                 err_count, resp_count, cycle_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/core_ctrl_pkg.sv
rtl/ctrl_stream_if.sv
rtl/ctrl_sid_router.sv
rtl/ctrl_fifo.sv
rtl/ctrl_cmd_proc.sv
rtl/core_settings.sv
rtl/core_ctrl_top.sv
tb/core_ctrl_assertions.sv
tb/tb_core_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the core control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core_ctrl -f list.f --Mdir obj_dir -o sim_core_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_core_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
exit 1
